//--- hw/usb_ctl_pkg.sv
package usb_ctl_pkg;

  // standard request codes (bRequest)
  localparam logic [7:0] REQ_GET_DESCRIPTOR    = 8'd6;
  localparam logic [7:0] REQ_SET_ADDRESS       = 8'd5;
  localparam logic [7:0] REQ_SET_CONFIGURATION = 8'd9;

  // descriptor types, high byte of wValue
  localparam logic [7:0] DESC_DEVICE = 8'd1;
  localparam logic [7:0] DESC_CONFIG = 8'd2;

  localparam int DEVICE_DESC_LEN    = 18;
  localparam int CONFIG_DESC_LEN    = 9;
  localparam int INTERFACE_DESC_LEN = 9;
  localparam int ENDPOINT_DESC_LEN  = 7;

  localparam int DESC_LEN_W = 16;  // same width as wLength

  // byte 0 of the packet ends up in the low bits
  typedef struct packed {
    logic [15:0] wLength;
    logic [15:0] wIndex;
    logic [15:0] wValue;
    logic [7:0]  bRequest;
    logic [7:0]  bmRequestType;
  } setup_fields_t;

  // raw bytes from the host, or the decoded fields
  typedef union packed {
    logic [7:0][7:0] raw;
    setup_fields_t   fields;
  } setup_pkt_u;

  typedef struct packed {
    logic                  start;       // one cycle pulse
    logic                  config_sel;  // 1 = configuration bundle
    logic [DESC_LEN_W-1:0] length;      // wLength of the request
  } desc_job_t;

  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] data;
  } desc_stream_t;

  typedef struct packed {
    logic in2;
    logic out1;
  } bulk_ep_t;

endpackage

//--- hw/descriptor_rom.sv
`timescale 1ns/1ps
module descriptor_rom #(
  parameter logic [15:0] VENDOR_ID   = 16'hF4CE,
  parameter logic [15:0] PRODUCT_ID  = 16'h0003,
  parameter int          USE_EP1_OUT = 1,
  parameter int          USE_EP2_IN  = 1
) (
  input  logic                                config_sel_i,
  input  logic [usb_ctl_pkg::DESC_LEN_W-1:0]  index_i,
  output logic [7:0]                          byte_o,
  output logic [usb_ctl_pkg::DESC_LEN_W-1:0]  total_len_o
);

  localparam int ROM_DEPTH = 32;  // largest bundle: both endpoints
  localparam int EP_COUNT  = int'(USE_EP1_OUT != 0) + int'(USE_EP2_IN != 0);
  localparam int CFG_LEN   = usb_ctl_pkg::CONFIG_DESC_LEN + usb_ctl_pkg::INTERFACE_DESC_LEN
                             + EP_COUNT * usb_ctl_pkg::ENDPOINT_DESC_LEN;

  localparam logic [15:0] DEV_TOTAL = 16'(usb_ctl_pkg::DEVICE_DESC_LEN);
  localparam logic [15:0] CFG_TOTAL = 16'(CFG_LEN);

  // byte 0 sits in the low bits
  localparam logic [ROM_DEPTH-1:0][7:0] DEVICE_ROM = {
    112'h0,           // padding
    8'h01,            // bNumConfigurations
    8'h00, 8'h00, 8'h00,  // no string indices
    16'h0100,         // bcdDevice 1.00
    PRODUCT_ID,
    VENDOR_ID,
    8'h40,            // bMaxPacketSize0 = 64
    8'h00, 8'h00, 8'h00,  // class, subclass, protocol
    16'h0200,         // bcdUSB 2.0
    usb_ctl_pkg::DESC_DEVICE,
    8'(usb_ctl_pkg::DEVICE_DESC_LEN)
  };

  localparam logic [71:0] CONFIG_DESC = {
    8'h32,            // 100 mA
    8'hC0,            // self-powered
    8'h00,
    8'h01,            // bConfigurationValue
    8'h01,            // one interface
    CFG_TOTAL,        // wTotalLength
    usb_ctl_pkg::DESC_CONFIG,
    8'(usb_ctl_pkg::CONFIG_DESC_LEN)
  };

  localparam logic [71:0] INTERFACE_DESC = {
    8'h00, 8'h00, 8'h00, 8'h00,
    8'(EP_COUNT),     // bNumEndpoints
    8'h00, 8'h00,
    8'h04,
    8'(usb_ctl_pkg::INTERFACE_DESC_LEN)
  };

  // bulk endpoints, 512 byte packets
  localparam logic [55:0] EP1_OUT_DESC = {8'h00, 16'h0200, 8'h02, 8'h01, 8'h05, 8'h07};
  localparam logic [55:0] EP2_IN_DESC  = {8'h00, 16'h0200, 8'h02, 8'h82, 8'h05, 8'h07};

  function automatic logic [ROM_DEPTH*8-1:0] build_config();
    logic [ROM_DEPTH*8-1:0] bundle;
    int ofs;
    bundle        = '0;
    bundle[71:0]  = CONFIG_DESC;
    bundle[143:72] = INTERFACE_DESC;
    ofs           = 144;
    if (USE_EP1_OUT != 0) begin
      bundle[ofs +: 56] = EP1_OUT_DESC;
      ofs               = ofs + 56;
    end
    if (USE_EP2_IN != 0) begin
      bundle[ofs +: 56] = EP2_IN_DESC;  // moves down when OUT1 is off
    end
    return bundle;
  endfunction

  localparam logic [ROM_DEPTH-1:0][7:0] CONFIG_ROM = build_config();

  always_comb begin
    total_len_o = config_sel_i ? CFG_TOTAL : DEV_TOTAL;
    byte_o      = 8'h00;  // past the end
    if (index_i < total_len_o) begin
      byte_o = config_sel_i ? CONFIG_ROM[index_i[4:0]] : DEVICE_ROM[index_i[4:0]];
    end
  end

endmodule

//--- hw/descriptor_streamer.sv
`timescale 1ns/1ps
module descriptor_streamer (
  input  logic                               clock,
  input  logic                               reset,
  input  usb_ctl_pkg::desc_job_t             job_i,
  input  logic                               desc_tready_i,
  input  logic [7:0]                         rom_byte_i,
  input  logic [usb_ctl_pkg::DESC_LEN_W-1:0] rom_total_len_i,
  output usb_ctl_pkg::desc_stream_t          desc_o,
  output logic [usb_ctl_pkg::DESC_LEN_W-1:0] rom_index_o,
  output logic                               rom_config_sel_o,
  output logic                               stream_end_o
);

  localparam int W = usb_ctl_pkg::DESC_LEN_W;

  logic valid_q, cfg_q, end_q;
  logic [W-1:0] index_q, len_q, job_len;
  logic last, xfer;

  // truncate to wLength
  assign job_len = (job_i.length < rom_total_len_i) ? job_i.length : rom_total_len_i;
  assign last    = (index_q == len_q - W'(1));
  assign xfer    = valid_q && desc_tready_i;

  // rom looks at the new job while it is being latched
  assign rom_config_sel_o = job_i.start ? job_i.config_sel : cfg_q;
  assign rom_index_o      = index_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
      end_q   <= 1'b0;
      cfg_q   <= 1'b0;
      index_q <= '0;
    end else begin
      end_q <= 1'b0;
      if (job_i.start) begin
        cfg_q   <= job_i.config_sel;
        index_q <= '0;
        valid_q <= (job_len != '0);
        end_q   <= (job_len == '0);  // empty stream ends at once
      end else if (xfer) begin
        if (last) begin
          valid_q <= 1'b0;
          end_q   <= 1'b1;
        end else begin
          index_q <= index_q + W'(1);
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (job_i.start) begin
      len_q <= job_len;
    end
  end

  assign desc_o.valid  = valid_q;
  assign desc_o.last   = valid_q && last;
  assign desc_o.data   = rom_byte_i;  // stable while index holds
  assign stream_end_o  = end_q;

endmodule

//--- hw/std_request_handler.sv
`timescale 1ns/1ps
module std_request_handler (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    setup_valid_i,
  input  usb_ctl_pkg::setup_pkt_u setup_i,
  input  logic                    stream_end_i,
  output usb_ctl_pkg::desc_job_t  job_o,
  output logic                    req_done_o,
  output logic                    req_error_o,
  output logic                    configured_o,
  output logic [6:0]              usb_addr_o,
  output logic [7:0]              usb_conf_o
);

  usb_ctl_pkg::setup_fields_t req;
  logic std_type, desc_dev, desc_cfg, accept;
  logic busy_q, done_q, error_q, job_start_q;
  logic job_cfg_q;
  logic [usb_ctl_pkg::DESC_LEN_W-1:0] job_len_q;
  logic [6:0] addr_q;
  logic [7:0] conf_q;

  assign req      = setup_i.fields;
  assign std_type = (req.bmRequestType[6:5] == 2'b00);  // standard type only
  assign desc_dev = (req.wValue[15:8] == usb_ctl_pkg::DESC_DEVICE);
  assign desc_cfg = (req.wValue[15:8] == usb_ctl_pkg::DESC_CONFIG);

  // no new request until the done or error cycle has passed
  assign accept = setup_valid_i && !busy_q && !done_q && !error_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      error_q     <= 1'b0;
      job_start_q <= 1'b0;
      addr_q      <= '0;
      conf_q      <= '0;
    end else begin
      done_q      <= 1'b0;
      error_q     <= 1'b0;
      job_start_q <= 1'b0;
      if (stream_end_i) begin  // descriptor fully sent
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (accept) begin
        if (!std_type) begin
          error_q <= 1'b1;
        end else begin
          case (req.bRequest)
            usb_ctl_pkg::REQ_GET_DESCRIPTOR: begin
              if (desc_dev || desc_cfg) begin
                busy_q      <= 1'b1;
                job_start_q <= 1'b1;
              end else begin
                error_q <= 1'b1;  // strings and others
              end
            end
            usb_ctl_pkg::REQ_SET_ADDRESS: begin
              addr_q <= req.wValue[6:0];  // no status stage here
              done_q <= 1'b1;
            end
            usb_ctl_pkg::REQ_SET_CONFIGURATION: begin
              if (req.wValue[7:0] > 8'd1) begin
                error_q <= 1'b1;
              end else begin
                conf_q <= req.wValue[7:0];
                done_q <= 1'b1;
              end
            end
            default: error_q <= 1'b1;
          endcase
        end
      end
    end
  end

  // job payload
  always_ff @(posedge clock) begin
    if (accept) begin
      job_cfg_q <= desc_cfg;
      job_len_q <= req.wLength;
    end
  end

  assign job_o.start      = job_start_q;
  assign job_o.config_sel = job_cfg_q;
  assign job_o.length     = job_len_q;

  assign req_done_o   = done_q;
  assign req_error_o  = error_q;
  assign configured_o = (conf_q != 8'd0);
  assign usb_addr_o   = addr_q;
  assign usb_conf_o   = conf_q;

endmodule

//--- hw/bulk_ep_select.sv
`timescale 1ns/1ps
module bulk_ep_select #(
  parameter int USE_EP1_OUT = 1,
  parameter int USE_EP2_IN  = 1
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  configured_i,
  input  logic                  blk_start_i,
  input  logic [3:0]            blk_endpt_i,
  input  logic                  ack_recv_i,
  input  logic                  blk_error_i,
  output usb_ctl_pkg::bulk_ep_t ep_sel_o,
  output usb_ctl_pkg::bulk_ep_t ep_ack_o,
  output usb_ctl_pkg::bulk_ep_t ep_err_o
);

  // bit 0 is OUT1, bit 1 is IN2
  localparam logic [1:0]      EP_ENABLE = {USE_EP2_IN != 0, USE_EP1_OUT != 0};
  localparam logic [1:0][3:0] EP_NUM    = {4'd2, 4'd1};

  logic [1:0] sel_q, ack_q, err_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= '0;
      ack_q <= '0;
      err_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        ack_q[i] <= sel_q[i] & ack_recv_i;
        err_q[i] <= sel_q[i] & blk_error_i;
        if (!configured_i || !EP_ENABLE[i]) begin
          sel_q[i] <= 1'b0;
        end else if (blk_start_i && blk_endpt_i == EP_NUM[i]) begin
          sel_q[i] <= 1'b1;
        end else if (ack_recv_i || blk_error_i) begin
          sel_q[i] <= 1'b0;  // transaction finished
        end
      end
    end
  end

  assign ep_sel_o = usb_ctl_pkg::bulk_ep_t'(sel_q);
  assign ep_ack_o = usb_ctl_pkg::bulk_ep_t'(ack_q);
  assign ep_err_o = usb_ctl_pkg::bulk_ep_t'(err_q);

endmodule

//--- hw/usb_ctl_top.sv
`timescale 1ns/1ps
module usb_ctl_top #(
  parameter logic [15:0] VENDOR_ID   = 16'hF4CE,
  parameter logic [15:0] PRODUCT_ID  = 16'h0003,
  parameter int          USE_EP1_OUT = 1,
  parameter int          USE_EP2_IN  = 1
) (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      setup_valid_i,
  input  usb_ctl_pkg::setup_pkt_u   setup_i,
  input  logic                      desc_tready_i,
  output usb_ctl_pkg::desc_stream_t desc_o,
  output logic                      req_done_o,
  output logic                      req_error_o,

  output logic                      configured_o,
  output logic [6:0]                usb_addr_o,
  output logic [7:0]                usb_conf_o,

  input  logic                      blk_start_i,
  input  logic [3:0]                blk_endpt_i,
  input  logic                      ack_recv_i,
  input  logic                      blk_error_i,
  output usb_ctl_pkg::bulk_ep_t     ep_sel_o,
  output usb_ctl_pkg::bulk_ep_t     ep_ack_o,
  output usb_ctl_pkg::bulk_ep_t     ep_err_o
);

  usb_ctl_pkg::desc_job_t                desc_job;
  logic                                  stream_end;
  logic [usb_ctl_pkg::DESC_LEN_W-1:0]    rom_index;
  logic [usb_ctl_pkg::DESC_LEN_W-1:0]    rom_total_len;
  logic                                  rom_config_sel;
  logic [7:0]                            rom_byte;

  std_request_handler std_request_handler_inst (
    .clock        (clock),
    .reset        (reset),
    .setup_valid_i(setup_valid_i),
    .setup_i      (setup_i),
    .stream_end_i (stream_end),
    .job_o        (desc_job),
    .req_done_o   (req_done_o),
    .req_error_o  (req_error_o),
    .configured_o (configured_o),
    .usb_addr_o   (usb_addr_o),
    .usb_conf_o   (usb_conf_o)
  );

  descriptor_streamer descriptor_streamer_inst (
    .clock           (clock),
    .reset           (reset),
    .job_i           (desc_job),
    .desc_tready_i   (desc_tready_i),
    .rom_byte_i      (rom_byte),
    .rom_total_len_i (rom_total_len),
    .desc_o          (desc_o),
    .rom_index_o     (rom_index),
    .rom_config_sel_o(rom_config_sel),
    .stream_end_o    (stream_end)
  );

  descriptor_rom #(
    .VENDOR_ID  (VENDOR_ID),
    .PRODUCT_ID (PRODUCT_ID),
    .USE_EP1_OUT(USE_EP1_OUT),
    .USE_EP2_IN (USE_EP2_IN)
  ) descriptor_rom_inst (
    .config_sel_i(rom_config_sel),
    .index_i     (rom_index),
    .byte_o      (rom_byte),
    .total_len_o (rom_total_len)
  );

  bulk_ep_select #(
    .USE_EP1_OUT(USE_EP1_OUT),
    .USE_EP2_IN (USE_EP2_IN)
  ) bulk_ep_select_inst (
    .clock       (clock),
    .reset       (reset),
    .configured_i(configured_o),
    .blk_start_i (blk_start_i),
    .blk_endpt_i (blk_endpt_i),
    .ack_recv_i  (ack_recv_i),
    .blk_error_i (blk_error_i),
    .ep_sel_o    (ep_sel_o),
    .ep_ack_o    (ep_ack_o),
    .ep_err_o    (ep_err_o)
  );

endmodule

//--- dv/usb_ctl_assertions.sv
`timescale 1ns/1ps
module usb_ctl_assertions (
  input logic                      clock,
  input logic                      reset,
  input usb_ctl_pkg::desc_stream_t desc_i,
  input logic                      tready_i,
  input logic                      done_i,
  input logic                      error_i
);

  last_with_valid: assert property (@(posedge clock) disable iff (reset)
    desc_i.last |-> desc_i.valid)
    else $error("stream last seen without valid");

  // stalled byte must not change
  hold_when_stalled: assert property (@(posedge clock) disable iff (reset)
    desc_i.valid && !tready_i |=> desc_i.valid && $stable(desc_i.data) && $stable(desc_i.last))
    else $error("stream changed while stalled");

  done_xor_error: assert property (@(posedge clock) disable iff (reset)
    !(done_i && error_i))
    else $error("done and error high together");

  quiet_in_reset: assert property (@(posedge clock)
    $past(reset) |-> !desc_i.valid)
    else $error("stream valid during reset");

endmodule

bind usb_ctl_top usb_ctl_assertions usb_ctl_assertions_inst (
  .clock   (clock),
  .reset   (reset),
  .desc_i  (desc_o),
  .tready_i(desc_tready_i),
  .done_i  (req_done_o),
  .error_i (req_error_o)
);

//--- dv/usb_ctl_tb.sv
`timescale 1ns/1ps
module usb_ctl_tb;

  localparam int MEM_WORDS      = 1024;
  localparam int CYCLES_PER_REC = 200;

  logic                      clock;
  logic                      reset;
  logic                      setup_valid_i;
  usb_ctl_pkg::setup_pkt_u   setup_i;
  logic                      desc_tready_i;
  usb_ctl_pkg::desc_stream_t desc_o;
  logic                      req_done_o;
  logic                      req_error_o;
  logic                      configured_o;
  logic [6:0]                usb_addr_o;
  logic [7:0]                usb_conf_o;
  logic                      blk_start_i;
  logic [3:0]                blk_endpt_i;
  logic                      ack_recv_i;
  logic                      blk_error_i;
  usb_ctl_pkg::bulk_ep_t     ep_sel_o;
  usb_ctl_pkg::bulk_ep_t     ep_ack_o;
  usb_ctl_pkg::bulk_ep_t     ep_err_o;

  logic [7:0]  stim [0:MEM_WORDS-1];
  logic [31:0] lfsr_state;
  logic [7:0]  got_bytes [$];
  logic        got_last [$];
  int          done_cnt;
  int          err_cnt;
  int          errors;
  int          checks;
  int          cycle_count;
  int          cycle_limit;

  usb_ctl_top usb_ctl_top_inst (.*);

  always #50 clock = ~clock;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // outputs are stable here and new back-pressure goes out for the next edge
  task automatic step();
    @(negedge clock);
    lfsr_state    = lfsr_next(lfsr_state);
    desc_tready_i = lfsr_state[0];
    if (desc_o.valid && desc_tready_i) begin  // moves on the coming rising edge
      got_bytes.push_back(desc_o.data);
      got_last.push_back(desc_o.last);
    end
    if (req_done_o) done_cnt++;
    if (req_error_o) err_cnt++;
  endtask

  function automatic int count_records();
    int p;
    int n;
    p = 0;
    n = 0;
    while (p < MEM_WORDS - 14 && (stim[p] == 8'h01 || stim[p] == 8'h02)) begin
      n++;
      p = p + ((stim[p] == 8'h01) ? 14 + int'(stim[p + 13]) : 6);
    end
    return n;
  endfunction

  task automatic run_setup(inout int p);
    usb_ctl_pkg::setup_pkt_u pkt;
    logic [7:0] outcome;
    logic [7:0] len;
    logic       resend;
    int         k;
    for (int i = 0; i < 8; i++) pkt.raw[i] = stim[p + 1 + i];
    outcome = stim[p + 9];
    resend  = (stim[p + 12] != 8'h00);
    len     = stim[p + 13];
    got_bytes.delete();
    got_last.delete();
    done_cnt      = 0;
    err_cnt       = 0;
    setup_i       = pkt;
    setup_valid_i = 1'b1;
    step();  // edge N is behind us
    setup_valid_i = 1'b0;
    if (outcome != 8'd2) begin
      check_value("done pulse", req_done_o, outcome == 8'd0);
      check_value("error pulse", req_error_o, outcome == 8'd1);
      check_value("address in pulse cycle", usb_addr_o, stim[p + 10]);
      check_value("configuration in pulse cycle", usb_conf_o, stim[p + 11]);
    end else begin
      k = 0;
      while (done_cnt == 0 && err_cnt == 0) begin
        step();
        k++;
        setup_valid_i = resend && k == 2;  // same packet again mid stream
      end
      setup_valid_i = 1'b0;
    end
    repeat (4) step();  // catch stray pulses or bytes
    check_value("done count", done_cnt, outcome != 8'd1);
    check_value("error count", err_cnt, outcome == 8'd1);
    check_value("byte count", got_bytes.size(), len);
    for (int i = 0; i < got_bytes.size() && i < len; i++) begin
      check_value($sformatf("byte %0d", i), got_bytes[i], stim[p + 14 + i]);
      check_value($sformatf("last flag %0d", i), got_last[i], i == len - 1);
    end
    check_value("address", usb_addr_o, stim[p + 10]);
    check_value("configuration", usb_conf_o, stim[p + 11]);
    check_value("configured", configured_o, stim[p + 11] != 8'h00);
    p = p + 14 + len;
  endtask

  task automatic run_bulk(inout int p);
    logic [7:0] ev_code;
    ev_code     = stim[p + 1];
    blk_start_i = (ev_code == 8'd1);
    blk_endpt_i = stim[p + 2][3:0];
    ack_recv_i  = (ev_code == 8'd2);
    blk_error_i = (ev_code == 8'd3);
    step();
    blk_start_i = 1'b0;
    ack_recv_i  = 1'b0;
    blk_error_i = 1'b0;
    check_value("select", ep_sel_o, stim[p + 3]);
    check_value("ack", ep_ack_o, stim[p + 4]);
    check_value("bulk error", ep_err_o, stim[p + 5]);
    step();
    check_value("select next cycle", ep_sel_o, stim[p + 3]);
    check_value("ack next cycle", ep_ack_o, 0);
    check_value("bulk error next cycle", ep_err_o, 0);
    p = p + 6;
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    int p;
    clock         = 1'b0;
    reset         = 1'b1;
    setup_valid_i = 1'b0;
    setup_i       = '0;
    desc_tready_i = 1'b0;
    blk_start_i   = 1'b0;
    blk_endpt_i   = '0;
    ack_recv_i    = 1'b0;
    blk_error_i   = 1'b0;
    lfsr_state    = 32'h4617_6491;
    errors        = 0;
    checks        = 0;
    cycle_count   = 0;
    $readmemh("dv/usb_ctl_stimulus.txt", stim);
    cycle_limit = (count_records() + 1) * CYCLES_PER_REC;
    if (count_records() == 0) begin
      errors++;
      $display("no records could be read from the stimulus file");
    end
    repeat (8) @(negedge clock);
    reset = 1'b0;
    check_value("valid after reset", desc_o.valid, 0);
    check_value("done after reset", req_done_o, 0);
    check_value("error after reset", req_error_o, 0);
    check_value("address after reset", usb_addr_o, 0);
    check_value("configuration after reset", usb_conf_o, 0);
    check_value("select after reset", ep_sel_o, 0);
    check_value("ack after reset", ep_ack_o, 0);
    check_value("bulk error after reset", ep_err_o, 0);
    p = 0;
    while (stim[p] == 8'h01 || stim[p] == 8'h02) begin
      if (stim[p] == 8'h01) run_setup(p);
      else run_bulk(p);
    end
    if (stim[p] !== 8'h00) begin
      errors++;
      $display("unknown record type %0h at word %0d of the stimulus file", stim[p], p);
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- dv/usb_ctl_stimulus.txt
// setup record 01, 8 raw bytes, outcome (0 done 1 error 2 stream), addr, conf, resend, L, L bytes
// bulk record 02, event (0 none 1 start 2 ack 3 error), endpoint, sel, ack, err; 00 ends the list
02 01 01 00 00 00
01 80 06 00 01 00 00 40 00 02 00 00 00 12
12 01 00 02 00 00 00 40 CE F4 03 00 00 01 00 00 00 01
01 80 06 00 02 00 00 09 00 02 00 00 01 09
09 02 20 00 01 01 00 C0 32
01 80 06 00 02 00 00 FF 00 02 00 00 00 20
09 02 20 00 01 01 00 C0 32 09 04 00 00 02 00 00 00 00
07 05 01 02 00 02 00 07 05 82 02 00 02 00
01 80 06 00 02 00 00 00 00 02 00 00 00 00
01 00 05 2A 00 00 00 00 00 00 2A 00 00 00
01 00 09 01 00 00 00 00 00 00 2A 01 00 00
01 00 09 03 00 00 00 00 00 01 2A 01 00 00
01 80 06 00 03 00 00 FF 00 01 2A 01 00 00
01 80 08 00 00 00 00 01 00 01 2A 01 00 00
02 01 02 02 00 00
02 02 00 00 02 00
02 01 01 01 00 00
02 03 00 00 00 01
02 01 03 00 00 00
02 01 02 02 00 00
01 00 09 00 00 00 00 00 00 00 2A 00 00 00
02 00 00 00 00 00
02 01 02 00 00 00
00

//--- usb_ctl.f
hw/usb_ctl_pkg.sv
hw/descriptor_rom.sv
hw/descriptor_streamer.sv
hw/std_request_handler.sv
hw/bulk_ep_select.sv
hw/usb_ctl_top.sv
dv/usb_ctl_assertions.sv
dv/usb_ctl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module usb_ctl_tb -f usb_ctl.f -o usb_ctl_sim

out=$(./obj_dir/usb_ctl_sim)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"
